/* common/lspcVideo_settings.svh */
`ifndef LSPCVIDEO_SETTINGS_SVH
`define LSPCVIDEO_SETTINGS_SVH

// Line and frame geometry
`define LINE_PIXELS 384
`define FRAME_LINES 264

// Sync high while pixel count below this
`define HSYNC_PIXELS 32
// Blank from this line to end of frame
`define ACTIVE_LINES 224

// Buffer pair swap pixel
`define FLIP_PIXEL 264
// Buffer address reload pixel
`define RELOAD_PIXEL 268

// Low three pixel bits at a free VRAM slot
`define SLOT_PHASE 7

// CPU register indexes
`define REG_VRAMADDR 0
`define REG_VRAMRW 1
`define REG_VRAMMOD 2

`endif

/* common/lspcPkg.sv */
package lspcPkg;

	// ==================================================
	// Video counters
	// ==================================================

	// Horizontal position, 384 pixels per line
	typedef logic [8:0] pixelCountT;

	// Line number in frame, 264 lines
	typedef logic [8:0] rasterCountT;

	// ==================================================
	// VRAM CPU port
	// ==================================================

	// VRAM word address
	// Bit 15 picks the fast zone on the real chip, kept as a plain bit here
	typedef logic [15:0] vramAddrT;

	// VRAM word, also the CPU data bus word
	typedef logic [15:0] vramDataT;

	// Register index from CPU address bits 3..1
	typedef logic [2:0] cpuRegSelT;

	// ==================================================
	// Write sequencer
	// ==================================================

	// IDLE     nothing waiting
	// PENDING  CPU data latched, waiting for a free slot
	// WRITE    one cycle, VRAM write strobe out
	typedef enum logic [1:0] {
		IDLE,
		PENDING,
		WRITE
	} writeStateT;

endpackage

/* timing/videoCounter.sv */
`include "lspcVideo_settings.svh"

module videoCounter (
	input  logic                 CLK,
	input  logic                 nRESETP,
	output lspcPkg::pixelCountT  pixelCount,
	output lspcPkg::rasterCountT rasterCount,
	output logic                 hSync,
	output logic                 vBlank
);

	import lspcPkg::*;

	// Last values before wrap
	localparam pixelCountT  pixelLast  = pixelCountT'(`LINE_PIXELS - 1);
	localparam rasterCountT rasterLast = rasterCountT'(`FRAME_LINES - 1);

	// Sync and blank thresholds
	localparam pixelCountT  syncEnd    = pixelCountT'(`HSYNC_PIXELS);
	localparam rasterCountT blankStart = rasterCountT'(`ACTIVE_LINES);

	// End of line, raster steps here
	logic lineEnd;

	assign lineEnd = (pixelCount == pixelLast);

	// ==================================================
	// Pixel and raster counters
	// ==================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			pixelCount  <= '0;
			rasterCount <= '0;
		end else begin
			// One pixel per clock
			if (lineEnd) begin
				pixelCount <= '0;
			end else begin
				pixelCount <= pixelCount + 1'b1;
			end

			// Next line at end of line, wrap at frame end
			if (lineEnd) begin
				if (rasterCount == rasterLast) begin
					rasterCount <= '0;
				end else begin
					rasterCount <= rasterCount + 1'b1;
				end
			end
		end
	end

	// ==================================================
	// Sync and blank levels
	// ==================================================

	// Sync pulse at start of line
	assign hSync = (pixelCount < syncEnd);

	// Blank over the bottom lines
	assign vBlank = (rasterCount >= blankStart);

	// Pixel counter stays inside the line
	pixelInLine: assert property (@(posedge CLK) disable iff (!nRESETP)
		pixelCount < pixelCountT'(`LINE_PIXELS));

endmodule

/* timing/lineBufferCtrl.sv */
`include "lspcVideo_settings.svh"

module lineBufferCtrl (
	input  logic                CLK,
	input  logic                nRESETP,
	input  lspcPkg::pixelCountT pixelCount,
	output logic                ss1,
	output logic                ss2,
	output logic                ldReload
);

	import lspcPkg::*;

	localparam pixelCountT flipAt   = pixelCountT'(`FLIP_PIXEL);
	localparam pixelCountT reloadAt = pixelCountT'(`RELOAD_PIXEL);

	// Which buffer renders and which shifts out
	logic flip;

	// ==================================================
	// Buffer pair select
	// ==================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			flip <= 1'b0;
		end else if (pixelCount == flipAt) begin
			// Swap once per line
			flip <= ~flip;
		end
	end

	// Complementary selects
	assign ss1 = flip;
	assign ss2 = ~flip;

	// ==================================================
	// Reload pulse
	// ==================================================

	// Buffers reload their write address
	// Single cycle, the cycle after the reload pixel
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			ldReload <= 1'b0;
		end else begin
			ldReload <= (pixelCount == reloadAt);
		end
	end

	// Never both buffers on the same side
	ssExclusive: assert property (@(posedge CLK) disable iff (!nRESETP)
		ss1 != ss2);

endmodule

/* vramPort/vramRegs.sv */
`include "lspcVideo_settings.svh"

module vramRegs (
	input  logic               CLK,
	input  logic               nRESETP,
	input  lspcPkg::cpuRegSelT cpuRegSel,
	input  lspcPkg::vramDataT  cpuWrData,
	input  logic               cpuWe,
	output lspcPkg::vramDataT  cpuRdData,
	output logic               writeRequest,
	input  logic               vramWe,
	output lspcPkg::vramAddrT  vramAddr,
	output lspcPkg::vramDataT  vramWrData
);

	import lspcPkg::*;

	localparam cpuRegSelT selAddr = cpuRegSelT'(`REG_VRAMADDR);
	localparam cpuRegSelT selRw   = cpuRegSelT'(`REG_VRAMRW);
	localparam cpuRegSelT selMod  = cpuRegSelT'(`REG_VRAMMOD);

	// Address step after each write
	vramAddrT vramMod;

	// Decoded write strobes
	logic wrAddr;
	logic wrRw;
	logic wrMod;

	assign wrAddr = cpuWe && (cpuRegSel == selAddr);
	assign wrRw   = cpuWe && (cpuRegSel == selRw);
	assign wrMod  = cpuWe && (cpuRegSel == selMod);

	// ==================================================
	// Address register
	// ==================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramAddr <= '0;
		end else if (wrAddr) begin
			// CPU load wins over auto-increment
			vramAddr <= vramAddrT'(cpuWrData);
		end else if (vramWe) begin
			// Step by modulo, 16-bit wrap
			vramAddr <= vramAddr + vramMod;
		end
	end

	// ==================================================
	// Modulo and write data
	// ==================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramMod <= '0;
		end else if (wrMod) begin
			vramMod <= vramAddrT'(cpuWrData);
		end
	end

	// Latest data replaces a write still waiting
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramWrData <= '0;
		end else if (wrRw) begin
			vramWrData <= cpuWrData;
		end
	end

	// Request to sequencer, same cycle as the CPU strobe
	assign writeRequest = wrRw;

	// ==================================================
	// CPU readback
	// ==================================================

	always_comb begin
		case (cpuRegSel)
			selAddr: cpuRdData = vramDataT'(vramAddr);
			selRw:   cpuRdData = vramWrData;
			selMod:  cpuRdData = vramDataT'(vramMod);
			default: cpuRdData = '0;
		endcase
	end

endmodule

/* vramPort/vramWriteSequencer.sv */
`include "lspcVideo_settings.svh"

module vramWriteSequencer (
	input  logic                CLK,
	input  logic                nRESETP,
	input  logic                writeRequest,
	input  lspcPkg::pixelCountT pixelCount,
	output logic                vramWe
);

	import lspcPkg::*;

	// Free slot every 8 pixels
	localparam logic [2:0] slotPhase = 3'(`SLOT_PHASE);

	writeStateT state;
	writeStateT stateNext;

	// High on the last pixel before a free slot
	logic slotFree;

	assign slotFree = (pixelCount[2:0] == slotPhase);

	// ==================================================
	// Next state
	// ==================================================

	always_comb begin
		stateNext = state;
		case (state)
			IDLE: begin
				if (writeRequest) begin
					stateNext = PENDING;
				end
			end
			// Wait for slot, a new request only swaps data
			PENDING: begin
				if (slotFree) begin
					stateNext = WRITE;
				end
			end
			// Single cycle, requeue if CPU wrote meanwhile
			WRITE: begin
				if (writeRequest) begin
					stateNext = PENDING;
				end else begin
					stateNext = IDLE;
				end
			end
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	// Write strobe for the whole WRITE cycle
	assign vramWe = (state == WRITE);

	// ==================================================
	// Checks
	// ==================================================

	// Strobe only lands in a slot
	weInSlot: assert property (@(posedge CLK) disable iff (!nRESETP)
		$rose(vramWe) |-> $past(pixelCount[2:0]) == slotPhase);

	// WRITE is one cycle
	writeOneCycle: assert property (@(posedge CLK) disable iff (!nRESETP)
		state == WRITE |=> state != WRITE);

endmodule

/* src/lspcVideoTop.sv */
module lspcVideoTop (
	input  logic                CLK,
	input  logic                nRESETP,
	input  lspcPkg::cpuRegSelT  cpuRegSel,
	input  lspcPkg::vramDataT   cpuWrData,
	input  logic                cpuWe,
	output lspcPkg::vramDataT   cpuRdData,
	output lspcPkg::pixelCountT pixelCount,
	output lspcPkg::rasterCountT rasterCount,
	output logic                hSync,
	output logic                vBlank,
	output logic                ss1,
	output logic                ss2,
	output logic                ldReload,
	output lspcPkg::vramAddrT   vramAddr,
	output lspcPkg::vramDataT   vramWrData,
	output logic                vramWe
);

	// CPU write waiting for a slot
	logic writeRequest;

	// ==================================================
	// Timing side
	// ==================================================

	videoCounter uVideoCounter (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.pixelCount (pixelCount),
		.rasterCount(rasterCount),
		.hSync      (hSync),
		.vBlank     (vBlank)
	);

	lineBufferCtrl uLineBufferCtrl (
		.CLK       (CLK),
		.nRESETP   (nRESETP),
		.pixelCount(pixelCount),
		.ss1       (ss1),
		.ss2       (ss2),
		.ldReload  (ldReload)
	);

	// ==================================================
	// CPU VRAM port
	// ==================================================

	vramRegs uVramRegs (
		.CLK         (CLK),
		.nRESETP     (nRESETP),
		.cpuRegSel   (cpuRegSel),
		.cpuWrData   (cpuWrData),
		.cpuWe       (cpuWe),
		.cpuRdData   (cpuRdData),
		.writeRequest(writeRequest),
		.vramWe      (vramWe),
		.vramAddr    (vramAddr),
		.vramWrData  (vramWrData)
	);

	// Slot timing comes from the pixel counter
	vramWriteSequencer uVramWriteSequencer (
		.CLK         (CLK),
		.nRESETP     (nRESETP),
		.writeRequest(writeRequest),
		.pixelCount  (pixelCount),
		.vramWe      (vramWe)
	);

endmodule

/* verif/lspcVideoChecks.svh */
`ifndef LSPCVIDEOCHECKS_SVH
`define LSPCVIDEOCHECKS_SVH

// ==================================================
// Check counters
// ==================================================

int passCount = 0;
int failCount = 0;

// Shared tally, values widened for printing
task automatic tally(input string name, input bit ok, input logic [31:0] exp,
		input logic [31:0] act);
	if (ok) begin
		passCount++;
	end else begin
		failCount++;
		$display("FAIL %s expected %0h actual %0h", name, exp, act);
	end
endtask

// Failures that have no value to compare
task automatic flagError(input string msg);
	failCount++;
	$display("ERROR %s", msg);
endtask

// ==================================================
// Typed compares, one per result kind
// ==================================================

task automatic checkPixel(input string name, input pixelCountT exp, input pixelCountT act);
	tally(name, act === exp, 32'(exp), 32'(act));
endtask

task automatic checkRaster(input string name, input rasterCountT exp, input rasterCountT act);
	tally(name, act === exp, 32'(exp), 32'(act));
endtask

// Single-bit levels and strobes
task automatic checkBit(input string name, input logic exp, input logic act);
	tally(name, act === exp, 32'(exp), 32'(act));
endtask

task automatic checkAddr(input string name, input vramAddrT exp, input vramAddrT act);
	tally(name, act === exp, 32'(exp), 32'(act));
endtask

task automatic checkData(input string name, input vramDataT exp, input vramDataT act);
	tally(name, act === exp, 32'(exp), 32'(act));
endtask

`endif

/* verif/lspcVideoTb.sv */
`include "lspcVideo_settings.svh"

module lspcVideoTb;

	import lspcPkg::*;

	// Writes in the run, sets the timeout budget
	localparam int WRITE_COUNT = 27;
	localparam int FRAME_CYCLES = `LINE_PIXELS * `FRAME_LINES;
	localparam int CYCLE_LIMIT = 2 * FRAME_CYCLES + 20 * WRITE_COUNT;

	logic CLK = 1'b0;
	logic nRESETP;
	cpuRegSelT cpuRegSel;
	vramDataT cpuWrData, cpuRdData, vramWrData;
	logic cpuWe, hSync, vBlank, ss1, ss2, ldReload, vramWe;
	pixelCountT pixelCount;
	rasterCountT rasterCount;
	vramAddrT vramAddr;

	// Reference model state
	pixelCountT pixM, prevPixM;
	rasterCountT rasM;
	logic flipM, reloadM, pendM, weM;
	vramAddrT addrM, modM, base, modv;
	vramDataT dataM, lastData;

	logic [31:0] lfsr = 32'd89762;
	int cycleCount = 0;
	int testFailBase = 0;

	`include "lspcVideoChecks.svh"

	lspcVideoTop dut (.*);

	always #5 CLK = ~CLK;

	// Run limit
	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, run did not reach its end", cycleCount);
			$display("Some tests failed");
			$finish;
		end
	end

	// 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsrBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// ==================================================
	// Reference model, one rising edge
	// ==================================================

	task automatic updateModel();
		logic slot;
		slot = (pixM[2:0] == 3'(`SLOT_PHASE));
		// CPU load beats the modulo step
		if (cpuWe && cpuRegSel == `REG_VRAMADDR) addrM = cpuWrData;
		else if (weM) addrM = addrM + modM;
		if (cpuWe && cpuRegSel == `REG_VRAMMOD) modM = cpuWrData;
		if (cpuWe && cpuRegSel == `REG_VRAMRW) dataM = cpuWrData;
		// Pending until slot, then one strobe cycle
		weM = pendM && slot;
		pendM = pendM ? !slot : (cpuWe && (cpuRegSel == `REG_VRAMRW));
		reloadM = (pixM == `RELOAD_PIXEL);
		if (pixM == `FLIP_PIXEL) flipM = ~flipM;
		prevPixM = pixM;
		if (pixM == `LINE_PIXELS - 1) begin
			pixM = '0;
			rasM = (rasM == `FRAME_LINES - 1) ? '0 : rasM + 1'b1;
		end else begin
			pixM = pixM + 1'b1;
		end
	endtask

	// Outputs are settled by the falling edge
	task automatic compareAll();
		checkPixel("pixelCount", pixM, pixelCount);
		checkRaster("rasterCount", rasM, rasterCount);
		checkBit("hSync", pixM < `HSYNC_PIXELS, hSync);
		checkBit("vBlank", rasM >= `ACTIVE_LINES, vBlank);
		checkBit("ss1", flipM, ss1);
		checkBit("ss2", ~flipM, ss2);
		checkBit("ldReload", reloadM, ldReload);
		checkBit("vramWe", weM, vramWe);
		checkAddr("vramAddr", addrM, vramAddr);
		checkData("vramWrData", dataM, vramWrData);
	endtask

	task automatic stepCycle();
		@(posedge CLK);
		updateModel();
		@(negedge CLK);
		compareAll();
	endtask

	// Plain register write, one strobe cycle
	task automatic writeReg(input cpuRegSelT sel, input vramDataT data);
		cpuRegSel = sel;
		cpuWrData = data;
		cpuWe = 1'b1;
		stepCycle();
		cpuWe = 1'b0;
		stepCycle();
	endtask

	// Data write, strobe must land within 9 cycles in a slot
	task automatic writeAndWait(input vramDataT data, input vramAddrT expAddr);
		int pulses;
		int pulseAt;
		int gap;
		pulses = 0;
		pulseAt = 0;
		writeReg(`REG_VRAMRW, data);
		for (int i = 2; i <= 12; i++) begin
			if (vramWe) begin
				pulses++;
				pulseAt = i;
				checkAddr("vramAddr at write", expAddr, vramAddr);
				checkData("vramWrData at write", data, vramWrData);
				checkBit("slot phase", 1'b1, prevPixM[2:0] == 3'(`SLOT_PHASE));
			end
			stepCycle();
		end
		if (pulses != 1 || pulseAt > 9) begin
			flagError($sformatf("write gave %0d vramWe pulses, last at cycle %0d",
				pulses, pulseAt));
		end
		gap = lfsrBits(2);
		repeat (gap) stepCycle();
	endtask

	task automatic endTest(input string name);
		$display("Test %s done, %0d errors", name, failCount - testFailBase);
		testFailBase = failCount;
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		nRESETP = 1'b0;
		cpuRegSel = '0;
		cpuWrData = '0;
		cpuWe = 1'b0;
		{pixM, prevPixM, rasM, addrM, modM, dataM} = '0;
		{flipM, reloadM, pendM, weM} = '0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		nRESETP = 1'b1;
		compareAll();
		endTest("reset");

		// Counters, buffer select and reload over a frame and a line
		repeat (FRAME_CYCLES + `LINE_PIXELS) stepCycle();
		endTest("timing");

		writeReg(`REG_VRAMMOD, vramDataT'(lfsrBits(16)));
		for (int n = 0; n < 16; n++) begin
			writeAndWait(vramDataT'(lfsrBits(16)), addrM);
		end
		endTest("random writes");

		// Address run from a random base by a random step
		base = vramAddrT'(lfsrBits(16));
		modv = vramAddrT'(lfsrBits(16));
		writeReg(`REG_VRAMADDR, base);
		writeReg(`REG_VRAMMOD, modv);
		for (int k = 0; k < 8; k++) begin
			lastData = vramDataT'(lfsrBits(16));
			writeAndWait(lastData, base + vramAddrT'(k) * modv);
		end
		endTest("modulo run");

		cpuRegSel = `REG_VRAMMOD;
		stepCycle();
		checkData("cpuRdData mod", modv, cpuRdData);
		cpuRegSel = `REG_VRAMRW;
		stepCycle();
		checkData("cpuRdData data", lastData, cpuRdData);
		cpuRegSel = `REG_VRAMADDR;
		stepCycle();
		checkData("cpuRdData addr", base + vramAddrT'(8) * modv, cpuRdData);
		for (int s = 3; s < 8; s++) begin
			cpuRegSel = cpuRegSelT'(s);
			stepCycle();
			checkData("cpuRdData unused", '0, cpuRdData);
		end
		endTest("readback");

		$display("Checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+common
+incdir+verif
common/lspcPkg.sv
timing/videoCounter.sv
timing/lineBufferCtrl.sv
vramPort/vramRegs.sv
vramPort/vramWriteSequencer.sv
src/lspcVideoTop.sv
verif/lspcVideoTb.sv
